//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_cfg_subsys
FILELIST := tb.f
OBJDIR   := obj_dir
PASS_MSG := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass only if the run prints the pass line.
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

//--- cfg_pkg.sv
package cfg_pkg;

    // core address and boot vector width.
    parameter int XLEN = 32;

    // decoded APB address bits.
    parameter int APB_AW = 12;

    // register offsets.
    parameter logic [APB_AW-1:0] CFGREG_RSTN      = 12'h000;
    parameter logic [APB_AW-1:0] CFGREG_BOOTVEC   = 12'h004;
    parameter logic [APB_AW-1:0] CFGREG_DDROFFSET = 12'h008;
    parameter logic [APB_AW-1:0] CFGREG_RSVREG0   = 12'h00C;
    parameter logic [APB_AW-1:0] CFGREG_RSVREG1   = 12'h010;

    // requester to slave, 47 bits.
    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [31:0]       pwdata;
    } apb_req_t;

    // slave to requester, 34 bits.
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // core memory request.
    typedef struct packed {
        logic            valid;
        logic            write;
        logic [XLEN-1:0] addr;
    } mem_req_t;

    // request between decode and remap stages.
    typedef struct packed {
        mem_req_t req;
        logic     in_ddr;
    } mem_stage_t;

    // translated request.
    typedef struct packed {
        logic            valid;
        logic            write;
        logic            in_ddr;
        logic [XLEN-1:0] addr;
    } mem_out_t;

endpackage

//--- cfg_subsys.sv
`timescale 1ns/1ps

module cfg_subsys #(
    parameter logic [cfg_pkg::XLEN-1:0] DDR_BASE        = 32'h8000_0000,
    parameter logic [cfg_pkg::XLEN-1:0] DDR_SIZE        = 32'h1000_0000,
    parameter int                       RST_HOLD_CYCLES = 4
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  cfg_pkg::apb_req_t         apb_req,
    output cfg_pkg::apb_rsp_t         apb_rsp,
    input  cfg_pkg::mem_req_t         mem_req,
    output cfg_pkg::mem_out_t         mem_out,
    output logic                      core_rstn,
    output logic                      boot_valid,
    output logic [cfg_pkg::XLEN-1:0]  boot_addr
);

    import cfg_pkg::*;

    logic            run;
    logic [XLEN-1:0] boot_vec;
    logic [31:0]     ddr_offset;
    mem_stage_t      stage_q;

    cfgreg i_cfgreg (
        .clk        (clk),
        .rstn       (rstn),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .run        (run),
        .boot_vec   (boot_vec),
        .ddr_offset (ddr_offset)
    );

    core_boot_ctrl #(
        .RST_HOLD_CYCLES (RST_HOLD_CYCLES)
    ) i_core_boot_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .run        (run),
        .boot_vec   (boot_vec),
        .core_rstn  (core_rstn),
        .boot_valid (boot_valid),
        .boot_addr  (boot_addr)
    );

    // two-stage request path.
    mem_region_decode #(
        .DDR_BASE (DDR_BASE),
        .DDR_SIZE (DDR_SIZE)
    ) i_mem_region_decode (
        .clk     (clk),
        .rstn    (rstn),
        .mem_req (mem_req),
        .stage_q (stage_q)
    );

    ddr_addr_remap #(
        .DDR_BASE (DDR_BASE)
    ) i_ddr_addr_remap (
        .clk        (clk),
        .rstn       (rstn),
        .stage_q    (stage_q),
        .ddr_offset (ddr_offset),
        .mem_out    (mem_out)
    );

endmodule

//--- cfgreg.sv
`timescale 1ns/1ps

module cfgreg (
    input  logic                      clk,
    input  logic                      rstn,
    input  cfg_pkg::apb_req_t         apb_req,
    output cfg_pkg::apb_rsp_t         apb_rsp,
    output logic                      run,
    output logic [cfg_pkg::XLEN-1:0]  boot_vec,
    output logic [31:0]               ddr_offset
);

    import cfg_pkg::*;

    logic [31:0] rsv_reg0;
    logic [31:0] rsv_reg1;
    logic [31:0] rdata_mux;
    logic [31:0] prdata_q;
    logic        apb_wr;

    // writes land in the setup phase.
    always_comb begin
        apb_wr = apb_req.psel & ~apb_req.penable & apb_req.pwrite;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run <= 1'b0;
        end else if (apb_wr && apb_req.paddr == CFGREG_RSTN) begin
            run <= apb_req.pwdata[0];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            boot_vec <= '0;
        end else if (apb_wr && apb_req.paddr == CFGREG_BOOTVEC) begin
            boot_vec <= apb_req.pwdata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ddr_offset <= '0;
        end else if (apb_wr && apb_req.paddr == CFGREG_DDROFFSET) begin
            ddr_offset <= apb_req.pwdata;
        end
    end

    // scratch registers, no function in hardware.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rsv_reg0 <= '0;
            rsv_reg1 <= '0;
        end else if (apb_wr) begin
            if (apb_req.paddr == CFGREG_RSVREG0) begin
                rsv_reg0 <= apb_req.pwdata;
            end
            if (apb_req.paddr == CFGREG_RSVREG1) begin
                rsv_reg1 <= apb_req.pwdata;
            end
        end
    end

    // unmapped offsets read as zero.
    always_comb begin
        rdata_mux = '0;
        case (apb_req.paddr)
            CFGREG_RSTN:      rdata_mux = {31'b0, run};
            CFGREG_BOOTVEC:   rdata_mux = boot_vec;
            CFGREG_DDROFFSET: rdata_mux = ddr_offset;
            CFGREG_RSVREG0:   rdata_mux = rsv_reg0;
            CFGREG_RSVREG1:   rdata_mux = rsv_reg1;
            default:          rdata_mux = '0;
        endcase
    end

    // valid in the access phase.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            prdata_q <= '0;
        end else begin
            prdata_q <= rdata_mux;
        end
    end

    always_comb begin
        apb_rsp.prdata  = prdata_q;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = 1'b0;
    end

endmodule

//--- core_boot_ctrl.sv
`timescale 1ns/1ps

module core_boot_ctrl #(
    parameter int RST_HOLD_CYCLES = 4
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      run,
    input  logic [cfg_pkg::XLEN-1:0]  boot_vec,
    output logic                      core_rstn,
    output logic                      boot_valid,
    output logic [cfg_pkg::XLEN-1:0]  boot_addr
);

    import cfg_pkg::*;

    localparam int CW = $clog2(RST_HOLD_CYCLES + 1);

    logic          run_q;
    logic          holding;
    logic [CW-1:0] hold_cnt;
    logic          run_rise;

    assign run_rise = run & ~run_q;

    // rise loads the count; release one edge after it hits zero.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run_q      <= 1'b0;
            holding    <= 1'b0;
            hold_cnt   <= '0;
            core_rstn  <= 1'b0;
            boot_valid <= 1'b0;
            boot_addr  <= '0;
        end else begin
            run_q      <= run;
            boot_valid <= 1'b0;
            if (!run) begin
                holding   <= 1'b0;
                hold_cnt  <= '0;
                core_rstn <= 1'b0;
            end else if (run_rise) begin
                holding  <= 1'b1;
                hold_cnt <= CW'(RST_HOLD_CYCLES - 1);
            end else if (holding) begin
                if (hold_cnt == '0) begin
                    holding    <= 1'b0;
                    core_rstn  <= 1'b1;
                    boot_valid <= 1'b1;
                    boot_addr  <= boot_vec;
                end else begin
                    hold_cnt <= hold_cnt - 1'b1;
                end
            end
        end
    end

endmodule

//--- ddr_addr_remap.sv
`timescale 1ns/1ps

module ddr_addr_remap #(
    parameter logic [cfg_pkg::XLEN-1:0] DDR_BASE = 32'h8000_0000
) (
    input  logic                clk,
    input  logic                rstn,
    input  cfg_pkg::mem_stage_t stage_q,
    input  logic [31:0]         ddr_offset,
    output cfg_pkg::mem_out_t   mem_out
);

    import cfg_pkg::*;

    logic [XLEN-1:0] remap_addr;
    logic            valid_q;
    logic            write_q;
    logic            in_ddr_q;
    logic [XLEN-1:0] addr_q;

    // rebase onto the programmed offset, wraps mod 2^XLEN.
    assign remap_addr = stage_q.in_ddr ? (stage_q.req.addr - DDR_BASE + ddr_offset)
                                       : stage_q.req.addr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_q.req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_q.req.valid) begin
            write_q  <= stage_q.req.write;
            in_ddr_q <= stage_q.in_ddr;
            addr_q   <= remap_addr;
        end
    end

    always_comb begin
        mem_out.valid  = valid_q;
        mem_out.write  = write_q;
        mem_out.in_ddr = in_ddr_q;
        mem_out.addr   = addr_q;
    end

endmodule

//--- mem_region_decode.sv
`timescale 1ns/1ps

module mem_region_decode #(
    parameter logic [cfg_pkg::XLEN-1:0] DDR_BASE = 32'h8000_0000,
    parameter logic [cfg_pkg::XLEN-1:0] DDR_SIZE = 32'h1000_0000
) (
    input  logic                clk,
    input  logic                rstn,
    input  cfg_pkg::mem_req_t   mem_req,
    output cfg_pkg::mem_stage_t stage_q
);

    import cfg_pkg::*;

    // one extra bit so a window ending at the top of memory does not wrap.
    localparam logic [XLEN:0] DDR_END = {1'b0, DDR_BASE} + {1'b0, DDR_SIZE};

    logic            hit;
    logic            valid_q;
    logic            write_q;
    logic            in_ddr_q;
    logic [XLEN-1:0] addr_q;

    assign hit = (mem_req.addr >= DDR_BASE) && ({1'b0, mem_req.addr} < DDR_END);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mem_req.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req.valid) begin
            write_q  <= mem_req.write;
            addr_q   <= mem_req.addr;
            in_ddr_q <= hit;
        end
    end

    always_comb begin
        stage_q.req.valid = valid_q;
        stage_q.req.write = write_q;
        stage_q.req.addr  = addr_q;
        stage_q.in_ddr    = in_ddr_q;
    end

endmodule

//--- tb.f
cfg_pkg.sv
cfgreg.sv
core_boot_ctrl.sv
mem_region_decode.sv
ddr_addr_remap.sv
cfg_subsys.sv
tb_clkgen.sv
tb_cfg_subsys_assert.sv
tb_cfg_subsys.sv

//--- tb_cfg_subsys.sv
`timescale 1ns/1ps

module tb_cfg_subsys;

    import cfg_pkg::*;

    localparam int          HOLD        = 4;
    localparam int          TIMEOUT_CYC = 64;
    localparam int          NRND        = 16;
    localparam logic [31:0] WIN_BASE    = 32'h8000_0000;
    localparam logic [31:0] WIN_SIZE    = 32'h1000_0000;

    typedef struct packed {
        logic [APB_AW-1:0] off;
        logic [31:0]       wdata;
        logic [31:0]       exp;
    } reg_entry_t;

    typedef struct packed {
        logic [31:0] addr;
        logic        wr;
        logic [31:0] exp_addr;
        logic        exp_ddr;
    } addr_entry_t;

    // offset, write data, readback.
    reg_entry_t reg_tab [6] = '{
        '{CFGREG_BOOTVEC,   32'h1000_0400, 32'h1000_0400},
        '{CFGREG_DDROFFSET, 32'h0040_0000, 32'h0040_0000},
        '{CFGREG_RSVREG0,   32'hdead_beef, 32'hdead_beef},
        '{CFGREG_RSVREG1,   32'h1234_5678, 32'h1234_5678},
        '{CFGREG_RSTN,      32'hffff_fffe, 32'h0000_0000},
        '{12'h020,          32'hffff_ffff, 32'h0000_0000}
    };

    // expected addresses assume ddr offset 0x0040_0000.
    addr_entry_t addr_tab [6] = '{
        '{32'h0000_1000, 1'b0, 32'h0000_1000, 1'b0},
        '{32'h7fff_fffc, 1'b1, 32'h7fff_fffc, 1'b0},
        '{32'h8000_0000, 1'b0, 32'h0040_0000, 1'b1},
        '{32'h8123_4560, 1'b1, 32'h0163_4560, 1'b1},
        '{32'h8fff_ffff, 1'b0, 32'h103f_ffff, 1'b1},
        '{32'h9000_0000, 1'b1, 32'h9000_0000, 1'b0}
    };

    logic [31:0] boot_tab [2] = '{32'h0000_1000, 32'hffff_f000};

    logic            clk;
    logic            rstn;
    apb_req_t        apb_req;
    apb_rsp_t        apb_rsp;
    mem_req_t        mem_req;
    mem_out_t        mem_out;
    logic            core_rstn;
    logic            boot_valid;
    logic [XLEN-1:0] boot_addr;

    int          mismatches = 0;
    int          timeouts = 0;
    int          cyc = 0;
    int          wr_cyc = 0;
    int          boot_cnt = 0;
    int          seed = 31319;
    logic [31:0] cur_offset;

    tb_clkgen #(.PERIOD_NS(8)) i_clkgen (.clk(clk));

    cfg_subsys i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .mem_req    (mem_req),
        .mem_out    (mem_out),
        .core_rstn  (core_rstn),
        .boot_valid (boot_valid),
        .boot_addr  (boot_addr)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // mid-cycle sample, one count per strobe cycle.
    always @(negedge clk) begin
        if (boot_valid) begin
            boot_cnt <= boot_cnt + 1;
        end
    end

    function automatic logic in_window(input logic [31:0] a);
        return (a >= WIN_BASE) && ((a - WIN_BASE) < WIN_SIZE);
    endfunction

    function automatic logic [31:0] rebase(input logic [31:0] a, input logic [31:0] off);
        if (in_window(a)) begin
            return a - WIN_BASE + off;
        end
        return a;
    endfunction

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, act, exp);
            mismatches++;
        end
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(posedge clk);
        #1;
        wr_cyc = cyc;
        apb_req.penable = 1'b1;
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        data = apb_rsp.prdata;
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic send_one(input addr_entry_t e);
        int t0;
        int waited;
        t0 = cyc;
        mem_req.valid = 1'b1;
        mem_req.write = e.wr;
        mem_req.addr  = e.addr;
        @(posedge clk);
        #1;
        mem_req.valid = 1'b0;
        waited = 0;
        while (mem_out.valid !== 1'b1 && waited < TIMEOUT_CYC) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (mem_out.valid !== 1'b1) begin
            $display("timeout: no translated request for address %08h", e.addr);
            timeouts++;
        end else begin
            check("mem_out latency", cyc - t0, 32'd2);
            check("mem_out.addr", mem_out.addr, e.exp_addr);
            check("mem_out.in_ddr", 32'(mem_out.in_ddr), 32'(e.exp_ddr));
            check("mem_out.write", 32'(mem_out.write), 32'(e.wr));
        end
    endtask

    // one request per cycle, each checked two cycles later.
    task automatic run_random_stream();
        addr_entry_t e [NRND];
        logic [31:0] rnd;
        for (int k = 0; k < NRND + 2; k++) begin
            if (k >= 2) begin
                check("stream mem_out.valid", 32'(mem_out.valid), 32'd1);
                check("stream mem_out.addr", mem_out.addr, e[k-2].exp_addr);
                check("stream mem_out.in_ddr", 32'(mem_out.in_ddr), 32'(e[k-2].exp_ddr));
                check("stream mem_out.write", 32'(mem_out.write), 32'(e[k-2].wr));
            end
            if (k < NRND) begin
                rnd = $random(seed);
                // every other address lands in the ddr window.
                if (k % 2 == 0) begin
                    rnd[31:28] = 4'h8;
                end
                e[k].addr     = rnd;
                e[k].wr       = rnd[5];
                e[k].exp_addr = rebase(rnd, cur_offset);
                e[k].exp_ddr  = in_window(rnd);
                mem_req.valid = 1'b1;
                mem_req.write = e[k].wr;
                mem_req.addr  = rnd;
            end else begin
                mem_req.valid = 1'b0;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_boot(input logic [31:0] vec);
        int          n0;
        int          waited;
        logic [31:0] rd;
        apb_write(CFGREG_BOOTVEC, vec);
        n0 = boot_cnt;
        apb_write(CFGREG_RSTN, 32'h1);
        check("core_rstn during hold", 32'(core_rstn), 32'd0);
        waited = 0;
        while (boot_valid !== 1'b1 && waited < TIMEOUT_CYC) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (boot_valid !== 1'b1) begin
            $display("timeout: boot_valid never came after run was set");
            timeouts++;
        end else begin
            check("boot_valid latency", cyc - wr_cyc, HOLD + 1);
            check("boot_addr", boot_addr, vec);
            check("core_rstn at boot", 32'(core_rstn), 32'd1);
        end
        apb_read(CFGREG_RSTN, rd);
        check("prdata[000] while running", rd, 32'd1);
        apb_write(CFGREG_RSTN, 32'h0);
        waited = 0;
        while (core_rstn !== 1'b0 && waited < TIMEOUT_CYC) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (core_rstn !== 1'b0) begin
            $display("timeout: core_rstn stayed high after run was cleared");
            timeouts++;
        end else begin
            check("core_rstn drop latency", cyc - wr_cyc, 32'd1);
        end
        check("boot_valid pulse count", boot_cnt - n0, 32'd1);
    endtask

    initial begin
        logic [31:0] rd;
        addr_entry_t wrap_e;
        int          total;
        rstn       = 1'b0;
        apb_req    = '0;
        mem_req    = '0;
        cur_offset = '0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        for (int i = 0; i < 6; i++) begin
            apb_read(reg_tab[i].off, rd);
            check($sformatf("reset prdata[%03h]", reg_tab[i].off), rd, 32'd0);
        end
        check("core_rstn after reset", 32'(core_rstn), 32'd0);
        check("boot_valid count after reset", boot_cnt, 32'd0);

        for (int i = 0; i < 6; i++) begin
            apb_write(reg_tab[i].off, reg_tab[i].wdata);
            apb_read(reg_tab[i].off, rd);
            check($sformatf("prdata[%03h]", reg_tab[i].off), rd, reg_tab[i].exp);
        end
        // later writes, the unmapped one too, leave earlier registers alone.
        for (int i = 0; i < 6; i++) begin
            apb_read(reg_tab[i].off, rd);
            check($sformatf("reread prdata[%03h]", reg_tab[i].off), rd, reg_tab[i].exp);
        end
        cur_offset = 32'h0040_0000;

        for (int i = 0; i < 2; i++) begin
            run_boot(boot_tab[i]);
        end

        for (int i = 0; i < 6; i++) begin
            send_one(addr_tab[i]);
        end

        // new offset, and the sum wraps past 2^32.
        apb_write(CFGREG_DDROFFSET, 32'hf800_0000);
        cur_offset = 32'hf800_0000;
        wrap_e = '{32'h8fff_fff0, 1'b1, 32'h07ff_fff0, 1'b1};
        send_one(wrap_e);
        run_random_stream();

        total = mismatches + timeouts + i_dut.i_assert.fail_cnt;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, i_dut.i_assert.fail_cnt);
        if (total == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- tb_cfg_subsys_assert.sv
`timescale 1ns/1ps

module tb_cfg_subsys_assert (
    input logic              clk,
    input logic              rstn,
    input cfg_pkg::apb_rsp_t apb_rsp,
    input cfg_pkg::mem_req_t mem_req,
    input cfg_pkg::mem_out_t mem_out,
    input logic              core_rstn,
    input logic              boot_valid
);

    int fail_cnt = 0;

    // slave is always ready and never errors.
    a_apb_rsp: assert property (@(posedge clk) apb_rsp.pready && !apb_rsp.pslverr)
        else begin
            $error("apb response not ready or flagged an error");
            fail_cnt++;
        end

    // fixed two-cycle request path.
    a_mem_latency: assert property (@(posedge clk) disable iff (!rstn)
        mem_out.valid == $past(mem_req.valid, 2))
        else begin
            $error("mem_out.valid does not follow mem_req.valid by two cycles");
            fail_cnt++;
        end

    a_boot_first: assert property (@(posedge clk) disable iff (!rstn)
        boot_valid |-> (core_rstn && !$past(core_rstn)))
        else begin
            $error("boot_valid outside the first cycle of core_rstn high");
            fail_cnt++;
        end

endmodule

bind cfg_subsys tb_cfg_subsys_assert i_assert (
    .clk        (clk),
    .rstn       (rstn),
    .apb_rsp    (apb_rsp),
    .mem_req    (mem_req),
    .mem_out    (mem_out),
    .core_rstn  (core_rstn),
    .boot_valid (boot_valid)
);

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    // free-running, starts low.
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

endmodule
